//--- Bender.yml
package:
  name: mini_rv_soc

sources:
  - hw/core_pkg.sv
  - hw/bus_pkg.sv
  - hw/hart_core.sv
  - hw/prog_mem.sv
  - hw/mmio_fabric.sv
  - hw/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_soc.sv

//--- hw/bus_pkg.sv
package bus_pkg;
    import core_pkg::*;

    typedef logic [63:0] baddr_t;   // bus byte address

    // one request from the hart, strobes are single-cycle
    typedef struct packed {
        baddr_t addr;
        xlen_t  wdata;
        logic   re;     // read strobe
        logic   we;     // write strobe
    } bus_req_t;

    // peripheral map
    localparam baddr_t DISPLAY_ADDR  = 64'h0000_0000_8000_0000;
    localparam baddr_t KEYBOARD_ADDR = 64'h0000_0000_8000_0010;

endpackage

//--- hw/core_pkg.sv
package core_pkg;

    typedef logic [63:0] xlen_t;    // one register or bus data word
    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;      // byte address, word aligned
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  irq_vec_t;

    // u-type field view of an instruction word
    typedef struct packed {
        logic [19:0] imm;     // upper immediate
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } utype_t;

    // what the execute stage does with ir this cycle
    typedef enum logic [1:0] {
        run,        // normal execution
        flush,      // ir holds a stale fetch, squash it
        load_wait,  // keyboard data captured into x5
        irq_busy    // executing inside the handler
    } exec_step_e;

    localparam pc_t RESET_PC_DEFAULT = 32'd44;

    // x5 is the only register wired to the peripherals
    localparam reg_idx_t IO_REG = 5'd5;

    // instruction patterns
    localparam instr_t op_lui        = 32'h0000_0037;  // opcode only, imm and rd go on top
    localparam instr_t op_load_key   = 32'hffff_ffff;  // x5 <- keyboard
    localparam instr_t op_store_disp = 32'hffff_ff7f;  // display <- x5
    localparam instr_t op_mret       = 32'h0000_0000;  // all-zero word
    localparam instr_t op_nop        = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- hw/hart_core.sv
module hart_core
    import core_pkg::*;
    import bus_pkg::*;
#(
    parameter pc_t      RESET_PC   = RESET_PC_DEFAULT,
    parameter irq_vec_t IRQ_VECTOR = 4'd1
) (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instr,       // word at pc, same cycle
    input  irq_vec_t irq_vector,
    input  xlen_t    bus_rdata,
    output pc_t      pc,
    output bus_req_t bus_req,
    output logic     irq_ack,
    output logic     heartbeat
);

    instr_t     ir;               // word fetched from last cycle's pc
    utype_t     ir_u;
    xlen_t      regs [32];
    pc_t        mepc;             // resume address
    logic       pending;          // inside the handler
    logic       load_step;        // current flush belongs to a load
    exec_step_e step;
    exec_step_e resume_step;

    baddr_t     req_addr;
    xlen_t      req_wdata;
    logic       req_re;
    logic       req_we;

    logic       exec_ok;
    logic       take_irq;
    logic       is_lui;
    logic       is_load;
    logic       is_store;
    logic       is_mret;
    xlen_t      imm_u;

    logic       rf_we;
    reg_idx_t   rf_waddr;
    xlen_t      rf_wdata;

    assign ir_u  = ir;
    assign imm_u = {{32{ir_u.imm[19]}}, ir_u.imm, 12'h000};  // sign-extended, shifted by 12

    assign resume_step = pending ? irq_busy : run;

    assign bus_req = '{addr: req_addr, wdata: req_wdata, re: req_re, we: req_we};

    // decode of ir, only in an executing step
    always_comb begin
        exec_ok  = (step == run) || (step == irq_busy);
        take_irq = (step == run) && (irq_vector == IRQ_VECTOR) && !pending;
        is_mret  = exec_ok && !take_irq && (ir == op_mret);
        is_load  = exec_ok && !take_irq && (ir == op_load_key);
        is_store = exec_ok && !take_irq && (ir == op_store_disp);
        is_lui   = exec_ok && !take_irq && (ir_u.opcode == op_lui[6:0]);

        // x0 stays zero
        rf_we    = (is_lui && (ir_u.rd != '0)) || (step == load_wait);
        rf_waddr = (step == load_wait) ? IO_REG : ir_u.rd;
        rf_wdata = (step == load_wait) ? bus_rdata : imm_u;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= RESET_PC;
            ir        <= op_nop;
            step      <= run;
            pending   <= 1'b0;
            load_step <= 1'b0;
            mepc      <= RESET_PC;  // stray mret restarts the program
            irq_ack   <= 1'b0;
            req_re    <= 1'b0;
            req_we    <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            ir        <= instr;
            pc        <= pc + 32'd4;  // default, overridden below
            irq_ack   <= 1'b0;
            req_re    <= 1'b0;
            req_we    <= 1'b0;

            if (take_irq) begin
                // ir is dropped, so resume at its address
                mepc    <= pc - 32'd4;
                pc      <= '0;      // handler at 0
                irq_ack <= 1'b1;
                pending <= 1'b1;
                step    <= flush;   // word fetched from old pc is wrong
            end else begin
                case (step)
                    flush: begin
                        if (load_step) begin
                            pc        <= pc;  // refetch the word after the load
                            load_step <= 1'b0;
                            step      <= load_wait;
                        end else begin
                            step <= resume_step;
                        end
                    end
                    load_wait: step <= resume_step;  // x5 written by the regfile block
                    default: begin
                        if (is_mret) begin
                            pc      <= mepc;
                            pending <= 1'b0;
                            step    <= flush;
                        end else if (is_load) begin
                            req_re    <= 1'b1;
                            pc        <= pc;  // hold
                            load_step <= 1'b1;
                            step      <= flush;
                        end else if (is_store) begin
                            req_we <= 1'b1;
                        end
                        // lui handled by the regfile block, anything else is a no-op
                    end
                endcase
            end
        end
    end

    // register file and request payload
    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
        if (is_load) begin
            req_addr <= KEYBOARD_ADDR;
        end
        if (is_store) begin
            req_addr  <= DISPLAY_ADDR;
            req_wdata <= regs[IO_REG];
        end
    end

    a_bus_excl: assert property (
        @(posedge clk) disable iff (!reset) !(bus_req.re && bus_req.we)
    ) else $error("read and write strobe together");

    a_ack_pulse: assert property (
        @(posedge clk) disable iff (!reset) irq_ack |=> !irq_ack
    ) else $error("irq_ack held for two cycles");

    a_pc_align: assert property (
        @(posedge clk) disable iff (!reset) pc[1:0] == 2'b00
    ) else $error("pc not word aligned");

endmodule

//--- hw/mmio_fabric.sv
module mmio_fabric
    import core_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output xlen_t    bus_rdata,
    input  logic     key_valid,
    input  xlen_t    key_code,
    output xlen_t    display_data,
    output logic     display_strobe
);

    xlen_t key_latch;   // last key seen
    logic  key_hit;
    logic  disp_hit;
    logic  disp_wr;
    logic  rd_hold;     // cycle after a keyboard read

    assign key_hit  = bus_req.addr == KEYBOARD_ADDR;
    assign disp_hit = bus_req.addr == DISPLAY_ADDR;
    assign disp_wr  = bus_req.we && disp_hit;  // other write targets dropped

    // read data stays up one cycle past the strobe, the hart samples it then
    assign bus_rdata = (key_hit && (bus_req.re || rd_hold)) ? key_latch : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_latch      <= '0;
            rd_hold        <= 1'b0;
            display_data   <= '0;
            display_strobe <= 1'b0;
        end else begin
            rd_hold        <= bus_req.re && key_hit;
            display_strobe <= disp_wr;  // one pulse per write
            if (key_valid) begin
                key_latch <= key_code;
            end
            if (disp_wr) begin
                display_data <= bus_req.wdata;
            end
        end
    end

    // keyboard is read-only
    a_no_key_write: assert property (
        @(posedge clk) disable iff (!reset) bus_req.we |-> !key_hit
    ) else $error("write to keyboard address");

endmodule

//--- hw/prog_mem.sv
module prog_mem
    import core_pkg::*;
#(
    parameter int PROG_WORDS = 64
) (
    input  logic                          clk,
    input  pc_t                           pc,
    output instr_t                        instr,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_WORDS)-1:0] prog_addr,
    input  instr_t                        prog_data
);

    localparam int AW = $clog2(PROG_WORDS);

    instr_t      mem [PROG_WORDS];
    logic [29:0] word_idx;   // pc without the byte offset
    logic        in_range;

    assign word_idx = pc[31:2];
    assign in_range = word_idx < PROG_WORDS;

    // past the end reads a zero word, which decodes as mret
    assign instr = in_range ? mem[word_idx[AW-1:0]] : op_mret;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    a_prog_addr: assert property (
        @(posedge clk) prog_we |-> (prog_addr < PROG_WORDS)
    ) else $error("program write outside the array");

endmodule

//--- hw/soc_top.sv
module soc_top
    import core_pkg::*;
    import bus_pkg::*;
#(
    parameter pc_t      RESET_PC   = RESET_PC_DEFAULT,
    parameter int       PROG_WORDS = 64,
    parameter irq_vec_t IRQ_VECTOR = 4'd1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  irq_vec_t                      irq_vector,
    input  logic                          key_valid,
    input  xlen_t                         key_code,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_WORDS)-1:0] prog_addr,
    input  instr_t                        prog_data,
    output pc_t                           pc,
    output xlen_t                         display_data,
    output logic                          display_strobe,
    output logic                          irq_ack,
    output logic                          heartbeat
);

    instr_t   instr;      // fetch path
    bus_req_t bus_req;    // hart to fabric
    xlen_t    bus_rdata;

    hart_core #(
        .RESET_PC   (RESET_PC),
        .IRQ_VECTOR (IRQ_VECTOR)
    ) hart_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .irq_vector (irq_vector),
        .bus_rdata  (bus_rdata),
        .pc         (pc),
        .bus_req    (bus_req),
        .irq_ack    (irq_ack),
        .heartbeat  (heartbeat)
    );

    prog_mem #(
        .PROG_WORDS (PROG_WORDS)
    ) prog_mem_i (
        .clk        (clk),
        .pc         (pc),
        .instr      (instr),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

    mmio_fabric fabric_i (
        .clk            (clk),
        .reset          (reset),
        .bus_req        (bus_req),
        .bus_rdata      (bus_rdata),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .display_data   (display_data),
        .display_strobe (display_strobe)
    );

endmodule

//--- sim.f
+incdir+include
hw/core_pkg.sv
hw/bus_pkg.sv
hw/hart_core.sv
hw/prog_mem.sv
hw/mmio_fabric.sv
hw/soc_top.sv
tests/tb_soc.sv

//--- include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// lui rd, imm
function automatic core_pkg::instr_t asm_lui(core_pkg::reg_idx_t rd, logic [19:0] imm);
    core_pkg::utype_t u;
    u.imm    = imm;
    u.rd     = rd;
    u.opcode = core_pkg::op_lui[6:0];
    return u;
endfunction

// value lui leaves in the register
function automatic core_pkg::xlen_t lui_value(logic [19:0] imm);
    int word;
    word = int'(imm) << 12;   // upper immediate in a 32-bit word
    return longint'(word);    // widened with its sign
endfunction

// x5 after one instruction, key is the latched keyboard value
function automatic core_pkg::xlen_t model_x5(core_pkg::instr_t w, core_pkg::xlen_t x5,
                                            core_pkg::xlen_t key);
    core_pkg::utype_t u;
    u = w;
    if (w == core_pkg::op_load_key) begin
        return key;
    end
    if (u.opcode == core_pkg::op_lui[6:0] && u.rd == core_pkg::IO_REG) begin
        return lui_value(u.imm);
    end
    return x5;
endfunction

function automatic bit model_is_store(core_pkg::instr_t w);
    return w == core_pkg::op_store_disp;
endfunction

// walks a straight-line program up to mret, queues every expected display value
function automatic void model_run(input core_pkg::instr_t prog[$], input core_pkg::xlen_t key,
                                  inout core_pkg::xlen_t x5, ref core_pkg::xlen_t exp_q[$]);
    foreach (prog[i]) begin
        if (prog[i] == core_pkg::op_mret) begin
            break;
        end
        if (model_is_store(prog[i])) begin
            exp_q.push_back(x5);
        end
        x5 = model_x5(prog[i], x5, key);
    end
endfunction

`endif

//--- tests/tb_soc.sv
module tb_soc
    import core_pkg::*;
();

    `include "tb_model.svh"

    localparam pc_t      RESET_PC   = RESET_PC_DEFAULT;
    localparam int       PROG_WORDS = 64;
    localparam irq_vec_t IRQ_VECTOR = 4'd1;
    localparam int       AW         = $clog2(PROG_WORDS);
    localparam int       BASE_WORD  = RESET_PC / 4;  // first word fetched after reset

    // program words of all runs, each run also costs a full image write
    localparam int PROG_LEN_SUM = 6 + 3 * 6 + 15 + 12;
    localparam int CYCLE_LIMIT  = 4 * PROG_LEN_SUM + 6 * (PROG_WORDS + 16) + 200;

    logic            clk;
    logic            reset;
    irq_vec_t        irq_vector;
    logic            key_valid;
    xlen_t           key_code;
    logic            prog_we;
    logic [AW-1:0]   prog_addr;
    instr_t          prog_data;
    pc_t             pc;
    xlen_t           display_data;
    logic            display_strobe;
    logic            irq_ack;
    logic            heartbeat;

    integer seed;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     acks = 0;           // irq_ack pulses in the current run
    bit     irq_allowed;
    logic   hb_prev;            // heartbeat one negedge ago
    bit     hb_live = 1'b0;     // reset was high one negedge ago
    xlen_t  exp_q[$];           // display values still to come
    instr_t no_handler[$];
    instr_t image [PROG_WORDS];

    soc_top #(
        .RESET_PC   (RESET_PC),
        .PROG_WORDS (PROG_WORDS),
        .IRQ_VECTOR (IRQ_VECTOR)
    ) dut_i (
        .clk (clk), .reset (reset), .irq_vector (irq_vector),
        .key_valid (key_valid), .key_code (key_code),
        .prog_we (prog_we), .prog_addr (prog_addr), .prog_data (prog_data),
        .pc (pc), .display_data (display_data), .display_strobe (display_strobe),
        .irq_ack (irq_ack), .heartbeat (heartbeat)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic report_fail(string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic compare_data(string name, xlen_t got, xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_pc(string name, pc_t got, pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // scoreboard, outputs settle at posedge so look at them half a cycle later
    always @(negedge clk) begin
        if (reset && display_strobe) begin
            if (exp_q.size() == 0) begin
                report_fail($sformatf("display strobe with no value due, data %h", display_data));
            end else begin
                compare_data("display_data", display_data, exp_q.pop_front());
            end
        end
        if (reset && irq_ack) begin
            acks++;
            if (!irq_allowed) report_fail($sformatf("irq_ack for vector %0d", irq_vector));
        end
        // heartbeat flips once per cycle out of reset
        if (reset && hb_live) begin
            compare_bit("heartbeat", heartbeat, ~hb_prev);
        end
        hb_prev = heartbeat;
        hb_live = reset;
    end

    // lui into x0, harmless, imm carries the whole word address
    function automatic instr_t filler_word(int a);
        return asm_lui(5'd0, 20'h5a000 | 20'(a));
    endfunction

    // writes the image under reset, returns on the falling edge that releases it
    task automatic start_run(input instr_t main_prog[$], input instr_t handler[$]);
        @(negedge clk);
        reset       = 1'b0;
        irq_allowed = 1'b0;
        acks        = 0;
        for (int a = 0; a < PROG_WORDS; a++) image[a] = filler_word(a);
        foreach (handler[i]) image[i] = handler[i];       // vector target is address 0
        foreach (main_prog[i]) image[BASE_WORD + i] = main_prog[i];
        for (int a = 0; a < PROG_WORDS; a++) begin
            prog_we   = 1'b1;
            prog_addr = AW'(a);
            prog_data = image[a];
            @(negedge clk);
        end
        prog_we = 1'b0;
        reset   = 1'b1;
    endtask

    task automatic finish_run();
        while (exp_q.size() != 0) @(negedge clk);   // global counter catches a hang
        repeat (6) @(negedge clk);                  // room for stray strobes
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    task automatic reset_values();
        int e;
        e = errors;
        repeat (2) @(negedge clk);   // reset low since time 0
        compare_pc("pc", pc, RESET_PC);
        compare_bit("irq_ack", irq_ack, 1'b0);
        compare_bit("display_strobe", display_strobe, 1'b0);
        compare_bit("heartbeat", heartbeat, 1'b0);
        end_test("reset_values", e);
    endtask

    task automatic lui_store_seq();
        instr_t prog[$];
        xlen_t  x5;
        int     e;
        e  = errors;
        x5 = '0;
        repeat (3) begin
            prog.push_back(asm_lui(IO_REG, 20'($random(seed))));
            prog.push_back(op_store_disp);
        end
        model_run(prog, '0, x5, exp_q);
        start_run(prog, no_handler);
        finish_run();
        end_test("lui_store", e);
    endtask

    task automatic load_store_seq();
        instr_t prog[$];
        xlen_t  x5;
        xlen_t  k0;
        xlen_t  k1;
        int     e;
        e = errors;
        for (int r = 0; r < 3; r++) begin
            prog.delete();
            for (int i = 0; i < 4; i++) prog.push_back(filler_word(BASE_WORD + i));  // keys settle
            prog.push_back(op_load_key);
            prog.push_back(op_store_disp);
            k0 = {$random(seed), $random(seed)};
            k1 = {$random(seed), $random(seed)};
            x5 = '0;
            model_run(prog, k1, x5, exp_q);   // second key is the one left in the latch
            start_run(prog, no_handler);
            key_valid = 1'b1;
            key_code  = k0;
            @(negedge clk);
            key_code  = k1;
            @(negedge clk);
            key_valid = 1'b0;
            finish_run();
        end
        end_test("load_store", e);
    endtask

    task automatic irq_round_trip();
        instr_t     part1[$];
        instr_t     part2[$];
        instr_t     handler[$];
        instr_t     main_prog[$];
        xlen_t      x5;
        exec_step_e step_now;
        int         e;
        e = errors;
        part1   = '{asm_lui(IO_REG, 20'($random(seed))), op_store_disp};
        part2   = '{asm_lui(IO_REG, 20'($random(seed))), op_store_disp};
        handler = '{asm_lui(IO_REG, 20'($random(seed))), op_store_disp, op_mret};
        main_prog = part1;
        for (int i = 0; i < 8; i++) main_prog.push_back(filler_word(100 + i));  // irq lands here
        foreach (part2[i]) main_prog.push_back(part2[i]);
        x5 = '0;
        model_run(part1, '0, x5, exp_q);
        model_run(handler, '0, x5, exp_q);   // handler value slots in between
        model_run(part2, '0, x5, exp_q);
        start_run(main_prog, handler);
        irq_allowed = 1'b1;
        while (!display_strobe) @(negedge clk);   // first main store out
        irq_vector = IRQ_VECTOR;
        @(negedge clk);
        while (!irq_ack) @(negedge clk);
        compare_pc("pc", pc, 32'h0);
        step_now = dut_i.hart_i.step;
        if (step_now != flush) begin
            report_fail($sformatf("hart in step %s, not flush, after irq entry", step_now.name()));
        end
        irq_vector = '0;
        finish_run();
        if (acks != 1) report_fail($sformatf("irq_ack pulsed %0d times instead of once", acks));
        end_test("irq_round_trip", e);
    endtask

    task automatic foreign_vectors();
        instr_t   prog[$];
        xlen_t    x5;
        irq_vec_t v;
        int       e;
        e = errors;
        prog.push_back(asm_lui(IO_REG, 20'($random(seed))));   // x5 defined before any store
        for (int i = 0; i < 10; i++) begin
            if ($random(seed) & 1) prog.push_back(op_store_disp);
            else if ($random(seed) & 1) prog.push_back(asm_lui(IO_REG, 20'($random(seed))));
            else prog.push_back(asm_lui(reg_idx_t'($random(seed)), 20'($random(seed))));
        end
        prog.push_back(op_store_disp);
        x5 = '0;
        model_run(prog, '0, x5, exp_q);
        start_run(prog, no_handler);
        while (exp_q.size() != 0) begin
            v = irq_vec_t'($random(seed));
            if (v == IRQ_VECTOR) v = v + 4'd1;   // anything but the live vector
            irq_vector = v;
            @(negedge clk);
        end
        irq_vector = '0;
        finish_run();
        end_test("foreign_vectors", e);
    endtask

    initial begin
        seed       = 32'h2516_cf9a;
        reset      = 1'b0;
        irq_vector = '0;
        key_valid  = 1'b0;
        key_code   = '0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        irq_allowed = 1'b0;
        reset_values();
        lui_store_seq();
        load_store_seq();
        irq_round_trip();
        foreign_vectors();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
